//--- rtl/echo_ctrl.sv
/*
 * Frame control for the UDP echo engine.
 * Accepts one receive header at a time, compares its destination port
 * with the echo port and then either steers the payload beats into the
 * payload FIFO or swallows them. The last beat of a frame returns the
 * FSM to idle so the next header can be taken.
 */
`timescale 1ns/1ps

module echo_ctrl
    import udp_echo_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    input  logic  rx_hdr_valid,
    input  port_t rx_dst_port,
    output logic  rx_hdr_ready,

    input  logic  rx_pay_valid,
    input  logic  rx_pay_last,
    output logic  rx_pay_ready,

    input  logic  hdr_full,
    input  logic  fifo_full,
    output logic  hdr_load,
    output logic  fifo_wr
);

    ctrl_state_t state;
    ctrl_state_t state_next;

    logic port_match;
    logic hdr_accept;
    logic pay_accept;

    assign port_match = (rx_dst_port == ECHO_PORT);

    // A matching header must wait until the reply slot is free
    assign rx_hdr_ready = (state == CTRL_IDLE) && (!port_match || !hdr_full);
    assign hdr_accept   = rx_hdr_valid && rx_hdr_ready;
    assign hdr_load     = hdr_accept && port_match;

    always_comb begin
        case (state)
            CTRL_ECHO: rx_pay_ready = !fifo_full;
            CTRL_DROP: rx_pay_ready = 1'b1;
            default:   rx_pay_ready = 1'b0;
        endcase
    end

    assign pay_accept = rx_pay_valid && rx_pay_ready;

    // Dropped beats are accepted but never written
    assign fifo_wr = pay_accept && (state == CTRL_ECHO);

    always_comb begin
        state_next = state;
        case (state)
            CTRL_IDLE: begin
                if (hdr_accept) begin
                    state_next = port_match ? CTRL_ECHO : CTRL_DROP;
                end
            end
            CTRL_ECHO, CTRL_DROP: begin
                if (pay_accept && rx_pay_last) begin
                    state_next = CTRL_IDLE;
                end
            end
            default: state_next = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= CTRL_IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

//--- rtl/echo_header_swap.sv
/*
 * Reply header register for the UDP echo engine.
 * Captures one request header on hdr_load and presents the reply on the
 * transmit header stream: ports swapped, the sender becomes the
 * destination, the local address and fixed TTL fill the rest.
 * hdr_full tells the control that the slot is still occupied.
 */
`timescale 1ns/1ps

module echo_header_swap
    import udp_echo_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     hdr_load,

    input  ip_addr_t rx_src_ip,
    input  port_t    rx_src_port,
    input  port_t    rx_dst_port,
    input  udp_len_t rx_length,

    output logic     hdr_full,

    output logic     tx_hdr_valid,
    input  logic     tx_hdr_ready,
    output ip_addr_t tx_src_ip,
    output ip_addr_t tx_dst_ip,
    output port_t    tx_src_port,
    output port_t    tx_dst_port,
    output ttl_t     tx_ttl,
    output udp_len_t tx_length
);

    // Slot occupancy
    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_full <= 1'b0;
        end else if (hdr_load) begin
            hdr_full <= 1'b1;
        end else if (tx_hdr_ready) begin
            hdr_full <= 1'b0;
        end
    end

    // Reply fields swapped on capture
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            tx_dst_ip   <= rx_src_ip;
            tx_src_port <= rx_dst_port;
            tx_dst_port <= rx_src_port;
            tx_length   <= rx_length;
        end
    end

    assign tx_hdr_valid = hdr_full;
    assign tx_src_ip    = LOCAL_IP;
    assign tx_ttl       = REPLY_TTL;

endmodule

//--- rtl/payload_fifo.sv
/*
 * Synchronous FIFO for payload beats with data, keep and last.
 * Write side is a plain enable gated by full; read side is a
 * valid/ready stream. Both flags are registered, so a written beat
 * shows on rd_valid one cycle after its write at the earliest.
 */
`timescale 1ns/1ps

module payload_fifo
    import udp_echo_pkg::*;
#(
    parameter int DEPTH = 16
) (
    input  logic  clk,
    input  logic  rst,

    input  data_t wr_data,
    input  keep_t wr_keep,
    input  logic  wr_last,
    input  logic  wr_en,
    output logic  full,

    output data_t rd_data,
    output keep_t rd_keep,
    output logic  rd_last,
    output logic  rd_valid,
    input  logic  rd_ready
);

    localparam int ADDR_W = $clog2(DEPTH);
    localparam int CNT_W  = $clog2(DEPTH + 1);

    data_t mem_data [DEPTH];
    keep_t mem_keep [DEPTH];
    logic  mem_last [DEPTH];

    logic [ADDR_W-1:0] wr_ptr;
    logic [ADDR_W-1:0] rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CNT_W-1:0]  count_next;

    logic do_wr;
    logic do_rd;

    assign do_wr = wr_en && !full;
    assign do_rd = rd_valid && rd_ready;

    always_comb begin
        count_next = count;
        if (do_wr && !do_rd) begin
            count_next = count + 1'b1;
        end else if (do_rd && !do_wr) begin
            count_next = count - 1'b1;
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_data[wr_ptr] <= wr_data;
            mem_keep[wr_ptr] <= wr_keep;
            mem_last[wr_ptr] <= wr_last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            full     <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (do_wr) begin
                wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count_next;
            full     <= (count_next == CNT_W'(DEPTH));
            rd_valid <= (count_next != '0);
        end
    end

    // Head of the queue
    assign rd_data = mem_data[rd_ptr];
    assign rd_keep = mem_keep[rd_ptr];
    assign rd_last = mem_last[rd_ptr];

endmodule

//--- rtl/udp_echo_pkg.sv
/*
 * Shared definitions for the UDP echo engine.
 * Holds the field widths, the typedefs for header fields and payload
 * beats, the echo constants and the control FSM states. Modules take
 * what they need through a wildcard import in their header.
 */
package udp_echo_pkg;

    // Payload beat geometry
    localparam int DATA_W = 64;
    localparam int KEEP_W = 8;

    typedef logic [15:0]       port_t;
    typedef logic [31:0]       ip_addr_t;
    typedef logic [15:0]       udp_len_t;
    typedef logic [7:0]        ttl_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [KEEP_W-1:0] keep_t;

    // Only this destination port is looped back
    localparam port_t ECHO_PORT = 16'd1234;

    // 192.168.1.128
    localparam ip_addr_t LOCAL_IP = {8'd192, 8'd168, 8'd1, 8'd128};

    localparam ttl_t REPLY_TTL = 8'd64;

    // Beats held between receive and transmit payload streams
    localparam int FIFO_DEPTH = 16;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_ECHO,
        CTRL_DROP
    } ctrl_state_t;

endpackage

//--- rtl/udp_echo_top.sv
/*
 * Top level of the UDP echo engine.
 * Sits between a parsed UDP receive side and a UDP transmit side.
 * Frames to the echo port come back as a swapped reply header plus the
 * same payload; all other frames are consumed silently.
 */
`timescale 1ns/1ps

module udp_echo_top
    import udp_echo_pkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // Receive header
    input  logic     rx_hdr_valid,
    output logic     rx_hdr_ready,
    input  ip_addr_t rx_src_ip,
    input  port_t    rx_src_port,
    input  port_t    rx_dst_port,
    input  udp_len_t rx_length,

    // Receive payload
    input  data_t    rx_pay_data,
    input  keep_t    rx_pay_keep,
    input  logic     rx_pay_last,
    input  logic     rx_pay_valid,
    output logic     rx_pay_ready,

    // Transmit header
    output logic     tx_hdr_valid,
    input  logic     tx_hdr_ready,
    output ip_addr_t tx_src_ip,
    output ip_addr_t tx_dst_ip,
    output port_t    tx_src_port,
    output port_t    tx_dst_port,
    output ttl_t     tx_ttl,
    output udp_len_t tx_length,

    // Transmit payload
    output data_t    tx_pay_data,
    output keep_t    tx_pay_keep,
    output logic     tx_pay_last,
    output logic     tx_pay_valid,
    input  logic     tx_pay_ready
);

    logic hdr_load;
    logic hdr_full;
    logic fifo_wr;
    logic fifo_full;

    echo_ctrl i_echo_ctrl (
        .clk          (clk),
        .rst          (rst),
        .rx_hdr_valid (rx_hdr_valid),
        .rx_dst_port  (rx_dst_port),
        .rx_hdr_ready (rx_hdr_ready),
        .rx_pay_valid (rx_pay_valid),
        .rx_pay_last  (rx_pay_last),
        .rx_pay_ready (rx_pay_ready),
        .hdr_full     (hdr_full),
        .fifo_full    (fifo_full),
        .hdr_load     (hdr_load),
        .fifo_wr      (fifo_wr)
    );

    echo_header_swap i_echo_header_swap (
        .clk          (clk),
        .rst          (rst),
        .hdr_load     (hdr_load),
        .rx_src_ip    (rx_src_ip),
        .rx_src_port  (rx_src_port),
        .rx_dst_port  (rx_dst_port),
        .rx_length    (rx_length),
        .hdr_full     (hdr_full),
        .tx_hdr_valid (tx_hdr_valid),
        .tx_hdr_ready (tx_hdr_ready),
        .tx_src_ip    (tx_src_ip),
        .tx_dst_ip    (tx_dst_ip),
        .tx_src_port  (tx_src_port),
        .tx_dst_port  (tx_dst_port),
        .tx_ttl       (tx_ttl),
        .tx_length    (tx_length)
    );

    // Payload path written only while echoing
    payload_fifo #(
        .DEPTH (FIFO_DEPTH)
    ) i_payload_fifo (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (rx_pay_data),
        .wr_keep  (rx_pay_keep),
        .wr_last  (rx_pay_last),
        .wr_en    (fifo_wr),
        .full     (fifo_full),
        .rd_data  (tx_pay_data),
        .rd_keep  (tx_pay_keep),
        .rd_last  (tx_pay_last),
        .rd_valid (tx_pay_valid),
        .rd_ready (tx_pay_ready)
    );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the UDP echo testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_udp_echo -o sim_udp_echo

./obj_dir/sim_udp_echo | tee sim.log

if grep -qx "No errors" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

//--- sim/tb_udp_echo.sv
/*
 * Directed testbench for the UDP echo engine.
 * Drives parsed UDP frames into the receive side, records everything that
 * leaves the transmit side and compares it against replies built from the
 * echo rules. Ends with an error count and a pass or fail line.
 */
`timescale 1ns/1ps

module tb_udp_echo
    import udp_echo_pkg::*;
();

    localparam int TIMEOUT = 500;

    logic     clk;
    logic     rst;
    logic     rx_hdr_valid;
    logic     rx_hdr_ready;
    ip_addr_t rx_src_ip;
    port_t    rx_src_port;
    port_t    rx_dst_port;
    udp_len_t rx_length;
    data_t    rx_pay_data;
    keep_t    rx_pay_keep;
    logic     rx_pay_last;
    logic     rx_pay_valid;
    logic     rx_pay_ready;
    logic     tx_hdr_valid;
    logic     tx_hdr_ready;
    ip_addr_t tx_src_ip;
    ip_addr_t tx_dst_ip;
    port_t    tx_src_port;
    port_t    tx_dst_port;
    ttl_t     tx_ttl;
    udp_len_t tx_length;
    data_t    tx_pay_data;
    keep_t    tx_pay_keep;
    logic     tx_pay_last;
    logic     tx_pay_valid;
    logic     tx_pay_ready;

    logic [31:0] lfsr;
    int          errors;

    // Header as {src_ip, dst_ip, src_port, dst_port, ttl, length}
    logic [119:0] exp_hdr[$];
    logic [119:0] got_hdr[$];
    // Beat as {data, keep, last}
    logic [72:0]  exp_beat[$];
    logic [72:0]  got_beat[$];

    udp_echo_top i_udp_echo_top (.*);

    initial clk = 1'b0;
    always #50 clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic draw_bits(input int n, output logic [63:0] v);
        int i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v = {v[62:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic collect_outputs();
        forever begin
            @(posedge clk);
            if (tx_hdr_valid && tx_hdr_ready) begin
                got_hdr.push_back({tx_src_ip, tx_dst_ip, tx_src_port, tx_dst_port,
                                   tx_ttl, tx_length});
            end
            if (tx_pay_valid && tx_pay_ready) begin
                got_beat.push_back({tx_pay_data, tx_pay_keep, tx_pay_last});
            end
        end
    endtask

    initial collect_outputs();

    task automatic send_frame(input ip_addr_t src_ip, input port_t src_port,
                              input port_t dst_port, input int beats);
        logic [63:0] bits;
        udp_len_t    len;
        keep_t       keep;
        logic        accepted;
        logic        echoed;
        int          i;
        int          waited;
        len    = udp_len_t'(8 + 8 * beats);
        echoed = (dst_port == 16'd1234);
        rx_src_ip    = src_ip;
        rx_src_port  = src_port;
        rx_dst_port  = dst_port;
        rx_length    = len;
        rx_hdr_valid = 1'b1;
        accepted = 1'b0;
        waited   = 0;
        while (!accepted && waited < TIMEOUT) begin
            @(posedge clk);
            accepted = rx_hdr_ready;
            waited++;
        end
        #1;
        rx_hdr_valid = 1'b0;
        if (!accepted) begin
            errors++;
            $display("Timeout at %0t: header to port %0d was never accepted", $time, dst_port);
            return;
        end
        // Reply has local source, sender as destination, swapped ports and TTL 64
        if (echoed) begin
            exp_hdr.push_back({32'hc0a8_0180, src_ip, dst_port, src_port, 8'd64, len});
        end
        for (i = 0; i < beats; i++) begin
            draw_bits(64, bits);
            rx_pay_data = bits;
            keep = 8'hff;
            if (i == beats - 1) begin
                draw_bits(3, bits);
                keep = keep_t'(8'hff >> bits[2:0]);
            end
            rx_pay_keep  = keep;
            rx_pay_last  = (i == beats - 1);
            rx_pay_valid = 1'b1;
            if (echoed) begin
                exp_beat.push_back({rx_pay_data, keep, rx_pay_last});
            end
            accepted = 1'b0;
            waited   = 0;
            while (!accepted && waited < TIMEOUT) begin
                @(posedge clk);
                accepted = rx_pay_ready;
                waited++;
            end
            #1;
            if (!accepted) begin
                errors++;
                rx_pay_valid = 1'b0;
                $display("Timeout at %0t: payload beat %0d was never accepted", $time, i);
                return;
            end
        end
        rx_pay_valid = 1'b0;
        rx_pay_last  = 1'b0;
    endtask

    task automatic wait_outputs();
        int waited;
        waited = 0;
        while ((got_hdr.size() < exp_hdr.size() || got_beat.size() < exp_beat.size())
               && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (got_hdr.size() < exp_hdr.size() || got_beat.size() < exp_beat.size()) begin
            errors++;
            $display("Timeout at %0t: echoed output did not arrive", $time);
        end
        // Quiet window to catch duplicates
        repeat (10) @(posedge clk);
        #1;
    endtask

    task automatic compare_outputs(input string name);
        int i;
        if (got_hdr.size() != exp_hdr.size()) begin
            errors++;
            $display("Fail at %0t: %s expected %0d headers, got %0d", $time, name,
                     exp_hdr.size(), got_hdr.size());
        end
        for (i = 0; i < exp_hdr.size() && i < got_hdr.size(); i++) begin
            if (got_hdr[i] !== exp_hdr[i]) begin
                errors++;
                $display("Fail at %0t: %s header %0d expected %h got %h", $time, name, i,
                         exp_hdr[i], got_hdr[i]);
            end
        end
        if (got_beat.size() != exp_beat.size()) begin
            errors++;
            $display("Fail at %0t: %s expected %0d beats, got %0d", $time, name,
                     exp_beat.size(), got_beat.size());
        end
        for (i = 0; i < exp_beat.size() && i < got_beat.size(); i++) begin
            if (got_beat[i] !== exp_beat[i]) begin
                errors++;
                $display("Fail at %0t: %s beat %0d expected %h got %h", $time, name, i,
                         exp_beat[i], got_beat[i]);
            end
        end
        exp_hdr.delete();
        got_hdr.delete();
        exp_beat.delete();
        got_beat.delete();
    endtask

    task automatic idle_outputs_quiet();
        repeat (5) begin
            @(posedge clk);
            if (tx_hdr_valid || tx_pay_valid) begin
                errors++;
                $display("Fail at %0t: transmit valid high while idle", $time);
            end
        end
        #1;
    endtask

    task automatic echo_one_frame();
        send_frame(32'h0a00_0005, 16'd5000, 16'd1234, 6);
        wait_outputs();
        compare_outputs("echo");
    endtask

    task automatic drop_other_port();
        send_frame(32'h0a00_0007, 16'd6000, 16'd80, 5);
        repeat (50) @(posedge clk);
        #1;
        compare_outputs("drop");
    endtask

    task automatic stall_transmit_side();
        tx_pay_ready = 1'b0;
        tx_hdr_ready = 1'b0;
        fork
            send_frame(32'h0a00_0009, 16'd7000, 16'd1234, 20);
            begin
                repeat (40) @(posedge clk);
                #1;
                tx_pay_ready = 1'b1;
                tx_hdr_ready = 1'b1;
            end
        join
        wait_outputs();
        compare_outputs("backpressure");
    endtask

    task automatic mixed_frames_back_to_back();
        send_frame(32'h0a00_000b, 16'd4001, 16'd1234, 3);
        send_frame(32'h0a00_000c, 16'd4002, 16'd53, 4);
        send_frame(32'h0a00_000d, 16'd4003, 16'd1234, 5);
        wait_outputs();
        compare_outputs("back to back");
    endtask

    initial begin
        errors       = 0;
        lfsr         = 32'h2e7e_8a26;
        rst          = 1'b1;
        rx_hdr_valid = 1'b0;
        rx_src_ip    = '0;
        rx_src_port  = '0;
        rx_dst_port  = '0;
        rx_length    = '0;
        rx_pay_data  = '0;
        rx_pay_keep  = '0;
        rx_pay_last  = 1'b0;
        rx_pay_valid = 1'b0;
        tx_hdr_ready = 1'b1;
        tx_pay_ready = 1'b1;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;

        idle_outputs_quiet();
        echo_one_frame();
        drop_other_port();
        stall_transmit_side();
        mixed_frames_back_to_back();

        $display("Error count: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- verilog.f
rtl/udp_echo_pkg.sv
rtl/echo_ctrl.sv
rtl/echo_header_swap.sv
rtl/payload_fifo.sv
rtl/udp_echo_top.sv
sim/tb_udp_echo.sv
